// ==== cpu_datapath.f ====
+incdir+rtl
rtl/lc3b_types.sv
rtl/instruction_fetch.sv
rtl/instruction_decode.sv
rtl/execution_module.sv
rtl/memory_module.sv
rtl/writeback_module.sv
rtl/cpu_datapath.sv
test/cpu_datapath_properties.sv
test/cpu_datapath_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_datapath

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/lc3b_types.sv
      - rtl/instruction_fetch.sv
      - rtl/instruction_decode.sv
      - rtl/execution_module.sv
      - rtl/memory_module.sv
      - rtl/writeback_module.sv
      - rtl/cpu_datapath.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/cpu_datapath_properties.sv
      - test/cpu_datapath_tb.sv

// ==== test/cpu_datapath_tb.sv ====
`timescale 1ns/100ps
`include "lc3b_consts.svh"

module cpu_datapath_tb import lc3b_types::*; ();

	localparam int RUN_CYCLES = 120;
	localparam int TOTAL_CYCLES = 6 * (4 + RUN_CYCLES) + 16;

	typedef struct packed {
		lc3b_word addr;
		lc3b_word data;
	} store_entry;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	lc3b_word mem_addr1, mem_rdata1, mem_addr2, mem_rdata2, mem_wdata2;
	logic mem_read1, mem_read2, mem_write2;
	lc3b_word imem [256];
	lc3b_word dmem [256];
	lc3b_word prog [$];
	store_entry store_log [$];
	store_entry exp_log [$];
	int errors = 0;
	int checks = 0;
	int tests = 0;

	cpu_datapath dut0 (
		.clk(clk), .rst_n(rst_n), .mem_addr1(mem_addr1), .mem_read1(mem_read1),
		.mem_rdata1(mem_rdata1), .mem_addr2(mem_addr2), .mem_read2(mem_read2),
		.mem_write2(mem_write2), .mem_rdata2(mem_rdata2), .mem_wdata2(mem_wdata2)
	);

	always #5 clk = ~clk;

	// data only while the port is strobed
	assign mem_rdata1 = mem_read1 ? imem[mem_addr1[8:1]] : 'x;
	assign mem_rdata2 = mem_read2 ? dmem[mem_addr2[8:1]] : 'x;

	always @(posedge clk) begin
		if (mem_write2)
			dmem[mem_addr2[8:1]] <= mem_wdata2;
	end

	always @(negedge clk) begin
		if (mem_write2)
			store_log.push_back('{addr: mem_addr2, data: mem_wdata2});  // mid-cycle sample
	end

	initial begin
		#(TOTAL_CYCLES * 2 * 10);
		$display("timeout: the run went on longer than all tests together should take");
		$display("Test FAILED");
		$finish;
	end

	function automatic lc3b_word sext5(logic [4:0] v);
		return {{11{v[4]}}, v};
	endfunction

	// condition code of a 16-bit result
	function automatic logic [2:0] nzp_of(lc3b_word v);
		if (v[15])
			return 3'b100;
		else if (v == 16'h0000)
			return 3'b010;
		else
			return 3'b001;
	endfunction

	function automatic lc3b_word alu_imm(logic [3:0] op, lc3b_reg dr, lc3b_reg sr, logic [4:0] imm);
		return {op, dr, sr, 1'b1, imm};
	endfunction

	function automatic lc3b_word alu_reg(logic [3:0] op, lc3b_reg dr, lc3b_reg sa, lc3b_reg sb);
		return {op, dr, sa, 3'b000, sb};
	endfunction

	function automatic lc3b_word mem_op(logic [3:0] op, lc3b_reg r, lc3b_reg base, logic [5:0] off);
		return {op, r, base, off};
	endfunction

	function automatic lc3b_word pc_rel(logic [3:0] op, logic [2:0] f, logic [8:0] off);
		return {op, f, off};
	endfunction

	task automatic check_word(lc3b_word exp, lc3b_word act, string msg);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %0t: %s expected %h got %h", $time, msg, exp, act);
		end
	endtask

	task automatic check_store(lc3b_word exp_addr, lc3b_word exp_data,
		lc3b_word act_addr, lc3b_word act_data);
		checks++;
		if (exp_addr !== act_addr || exp_data !== act_data) begin
			errors++;
			$display("[FAIL] %0t: store expected %h <- %h got %h <- %h", $time,
				exp_addr, exp_data, act_addr, act_data);
		end
	endtask

	// program words from prog, then the self loop, rest never-taken BRs
	task automatic load_program();
		for (int i = 0; i < 256; i++) begin
			imem[i] = {7'b0000000, i[8:0]};
			dmem[i] = {i[7:0], ~i[7:0]};
		end
		prog.push_back(pc_rel(4'b0000, 3'b111, 9'h1ff));
		foreach (prog[i])
			imem[(`LC3B_RESET_PC >> 1) + i] = prog[i];
	endtask

	task automatic run_program(int cycles);
		@(negedge clk);
		rst_n = 1'b0;
		store_log.delete();
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		repeat (cycles) @(negedge clk);
	endtask

	task automatic compare_log(string name, int err_before);
		check_word(lc3b_word'(exp_log.size()), lc3b_word'(store_log.size()), "store count");
		for (int i = 0; i < exp_log.size() && i < store_log.size(); i++)
			check_store(exp_log[i].addr, exp_log[i].data, store_log[i].addr, store_log[i].data);
		tests++;
		if (errors == err_before)
			$display("[%s] ok", name);
		else
			$display("[%s] errors: %0d", name, errors - err_before);
		prog.delete();
		exp_log.delete();
	endtask

	task automatic alu_chain_test();
		logic [4:0] a, b, c, d;
		lc3b_word r [7];
		int e0;
		e0 = errors;
		a = $urandom;
		b = $urandom;
		c = $urandom;
		d = $urandom;
		prog = '{alu_imm(4'b0101, 7, 7, 0), alu_imm(4'b0101, 0, 0, 0), alu_imm(4'b0001, 0, 0, a),
			alu_imm(4'b0101, 1, 1, 0), alu_imm(4'b0001, 1, 1, b), alu_reg(4'b0001, 2, 0, 1),
			alu_imm(4'b0101, 3, 2, c), alu_reg(4'b0101, 4, 2, 0), {4'b1001, 3'd5, 3'd3, 6'h3f},
			alu_imm(4'b0001, 6, 5, d)};
		r[0] = sext5(a);
		r[1] = sext5(b);
		r[2] = r[0] + r[1];
		r[3] = r[2] & sext5(c);
		r[4] = r[2] & r[0];
		r[5] = ~r[3];
		r[6] = r[5] + sext5(d);
		for (int k = 0; k < 5; k++) begin
			prog.push_back(mem_op(4'b0111, lc3b_reg'(k + 2), 7, k));
			exp_log.push_back('{addr: lc3b_word'(2 * k), data: r[k + 2]});
		end
		load_program();
		run_program(RUN_CYCLES);
		compare_log("alu_chain", e0);
	endtask

	task automatic load_use_test();
		logic [4:0] imm;
		lc3b_word w0, w1;
		int e0;
		e0 = errors;
		imm = $urandom;
		prog = '{alu_imm(4'b0101, 7, 7, 0), mem_op(4'b0110, 1, 7, 20), alu_imm(4'b0001, 2, 1, imm),
			mem_op(4'b0111, 2, 7, 2), mem_op(4'b0110, 3, 7, 21), alu_reg(4'b0001, 4, 3, 3),
			mem_op(4'b0111, 4, 7, 3)};
		load_program();
		w0 = $urandom;
		w1 = $urandom;
		dmem[20] = w0;
		dmem[21] = w1;
		exp_log = '{'{addr: 16'h0004, data: w0 + sext5(imm)}, '{addr: 16'h0006, data: w1 + w1}};
		run_program(RUN_CYCLES);
		compare_log("load_use", e0);
	endtask

	task automatic lea_test();
		logic [8:0] off;
		int e0;
		e0 = errors;
		off = $urandom;
		prog = '{alu_imm(4'b0101, 7, 7, 0), pc_rel(4'b1110, 3'd1, off), mem_op(4'b0111, 1, 7, 5)};
		exp_log = '{'{addr: 16'h000a,
			data: `LC3B_RESET_PC + 16'd2 + 16'd2 + {{6{off[8]}}, off, 1'b0}}};
		load_program();
		run_program(RUN_CYCLES);
		compare_log("lea", e0);
	endtask

	task automatic branch_cc_test();
		logic [4:0] set_imm [6] = '{5'h1d, 5'h1d, 5'h00, 5'h00, 5'h05, 5'h05};
		logic [2:0] cond [6] = '{3'b100, 3'b010, 3'b010, 3'b001, 3'b001, 3'b100};
		int e0;
		e0 = errors;
		prog = '{alu_imm(4'b0101, 7, 7, 0), alu_imm(4'b0101, 6, 6, 0), alu_imm(4'b0001, 6, 6, 11)};
		for (int k = 0; k < 6; k++) begin
			prog.push_back(alu_imm(4'b0001, 0, 7, set_imm[k]));  // sets n, z or p
			prog.push_back(pc_rel(4'b0000, cond[k], 9'd2));
			prog.push_back(pc_rel(4'b1110, 3'd5, 9'd0));  // filler, no cc or memory
			prog.push_back(mem_op(4'b0111, 6, 7, k));
			if ((cond[k] & nzp_of(sext5(set_imm[k]))) == 3'b000)  // not taken, marker stored
				exp_log.push_back('{addr: lc3b_word'(2 * k), data: 16'd11});
		end
		load_program();
		run_program(RUN_CYCLES);
		compare_log("branch_cc", e0);
	endtask

	task automatic flush_test();
		int e0;
		e0 = errors;
		// four stores right behind the taken BRp, target is the last store
		prog = '{alu_imm(4'b0101, 7, 7, 0), alu_imm(4'b0101, 6, 6, 0), alu_imm(4'b0001, 6, 6, 7),
			alu_imm(4'b0001, 0, 7, 1), pc_rel(4'b0000, 3'b001, 9'd4), mem_op(4'b0111, 6, 7, 8),
			mem_op(4'b0111, 6, 7, 9), mem_op(4'b0111, 6, 7, 10), mem_op(4'b0111, 6, 7, 11),
			mem_op(4'b0111, 6, 7, 12)};
		exp_log = '{'{addr: 16'd24, data: 16'd7}};
		load_program();
		run_program(RUN_CYCLES);
		compare_log("flush", e0);
	endtask

	task automatic reset_rerun_test();
		int e0;
		int held;
		e0 = errors;
		prog = '{alu_imm(4'b0101, 7, 7, 0), alu_imm(4'b0101, 1, 1, 0), alu_imm(4'b0001, 1, 1, 9),
			mem_op(4'b0111, 1, 7, 6), mem_op(4'b0111, 1, 7, 7)};
		exp_log = '{'{addr: 16'd12, data: 16'd9}, '{addr: 16'd14, data: 16'd9}};
		load_program();
		run_program(8);
		rst_n = 1'b0;  // cut in mid program
		held = store_log.size();
		repeat (4) @(negedge clk);
		check_word(lc3b_word'(held), lc3b_word'(store_log.size()), "stores during reset");
		run_program(RUN_CYCLES);
		compare_log("reset_rerun", e0);
	endtask

	initial begin
		int seed_dummy;
		seed_dummy = $urandom(32'h750c_fad7);
		rst_n = 1'b0;
		prog.delete();
		load_program();
		prog.delete();
		alu_chain_test();
		load_use_test();
		lea_test();
		branch_cc_test();
		flush_test();
		reset_rerun_test();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule : cpu_datapath_tb

// ==== test/cpu_datapath_properties.sv ====
`timescale 1ns/100ps

module cpu_datapath_properties import lc3b_types::*; (
	input logic     clk,
	input logic     rst_n,
	input lc3b_word mem_addr1,
	input logic     mem_read1,
	input logic     mem_read2,
	input logic     mem_write2,
	input logic     stall,
	input logic     branch_enable
);

	assert property (@(posedge clk) disable iff (!rst_n) !(mem_read2 && mem_write2))
		else $error("port 2 read and write strobes high together");

	// strobes stay low while reset is held
	assert property (@(posedge clk) !rst_n |-> !mem_read1 && !mem_read2 && !mem_write2)
		else $error("memory strobe high during reset");

	assert property (@(posedge clk) disable iff (!rst_n) stall |=> $stable(mem_addr1))
		else $error("fetch address moved during a stall");

	// flushed slots reach the memory stage as bubbles
	assert property (@(posedge clk) disable iff (!rst_n)
		branch_enable |=> (!mem_read2 && !mem_write2) [*3])
		else $error("port 2 active right after a taken branch");

endmodule : cpu_datapath_properties

bind cpu_datapath cpu_datapath_properties props0 (
	.clk(clk), .rst_n(rst_n), .mem_addr1(mem_addr1), .mem_read1(mem_read1),
	.mem_read2(mem_read2), .mem_write2(mem_write2), .stall(stall),
	.branch_enable(branch_enable)
);

// ==== rtl/cpu_datapath.sv ====
`timescale 1ns/100ps

module cpu_datapath import lc3b_types::*; (
	input  logic        clk,
	input  logic        rst_n,
	output lc3b_word    mem_addr1,
	output logic        mem_read1,
	input  lc3b_word    mem_rdata1,
	output lc3b_word    mem_addr2,
	output logic        mem_read2,
	output logic        mem_write2,
	input  lc3b_word    mem_rdata2,
	output lc3b_word    mem_wdata2
);

	lc3b_stage if_stage;
	lc3b_stage id_stage;
	lc3b_stage ex_stage;
	lc3b_stage mem_stage;
	lc3b_word  sr1;
	lc3b_word  sr2;
	lc3b_word  ex_alu;
	lc3b_word  store_data;
	lc3b_word  mem_alu;
	lc3b_word  mdr;
	logic      stall;
	logic      wb_load;
	lc3b_reg   wb_dest;
	lc3b_word  wb_data;
	logic      branch_enable;  // also the flush for every stage
	lc3b_word  br_target;

	instruction_fetch if_logic (
		.clk(clk), .rst_n(rst_n), .stall(stall), .branch_enable(branch_enable),
		.br_target(br_target), .mem_addr1(mem_addr1), .mem_read1(mem_read1),
		.mem_rdata1(mem_rdata1), .if_stage(if_stage)
	);

	instruction_decode id_logic (
		.clk(clk), .rst_n(rst_n), .if_stage(if_stage), .branch_enable(branch_enable),
		.wb_load(wb_load), .wb_dest(wb_dest), .wb_data(wb_data), .stall(stall),
		.id_stage(id_stage), .sr1(sr1), .sr2(sr2)
	);

	execution_module ex_module (
		.clk(clk), .rst_n(rst_n), .id_stage(id_stage), .sr1(sr1), .sr2(sr2),
		.branch_enable(branch_enable), .ex_stage(ex_stage), .alu(ex_alu),
		.store_data(store_data)
	);

	memory_module mem_module (
		.clk(clk), .rst_n(rst_n), .ex_stage(ex_stage), .alu(ex_alu),
		.store_data(store_data), .branch_enable(branch_enable), .mem_addr2(mem_addr2),
		.mem_read2(mem_read2), .mem_write2(mem_write2), .mem_wdata2(mem_wdata2),
		.mem_rdata2(mem_rdata2), .mem_stage(mem_stage), .mem_alu(mem_alu), .mdr(mdr)
	);

	writeback_module wb_module (
		.clk(clk), .rst_n(rst_n), .mem_stage(mem_stage), .mem_alu(mem_alu), .mdr(mdr),
		.wb_load(wb_load), .wb_dest(wb_dest), .wb_data(wb_data),
		.branch_enable(branch_enable), .br_target(br_target)
	);

endmodule : cpu_datapath

// ==== rtl/writeback_module.sv ====
`timescale 1ns/100ps

module writeback_module import lc3b_types::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  lc3b_stage   mem_stage,
	input  lc3b_word    mem_alu,
	input  lc3b_word    mdr,
	output logic        wb_load,
	output lc3b_reg     wb_dest,
	output lc3b_word    wb_data,
	output logic        branch_enable,
	output lc3b_word    br_target
);

	logic [2:0] cc;       // n z p
	logic [2:0] cc_next;

	assign wb_data = (mem_stage.cw.opcode == op_ldr) ? mdr : mem_alu;
	assign wb_load = mem_stage.cw.valid && mem_stage.cw.regfile_load;
	assign wb_dest = mem_stage.cw.dest;

	always_comb begin
		if (wb_data[15])
			cc_next = 3'b100;
		else if (wb_data == 16'h0000)
			cc_next = 3'b010;
		else
			cc_next = 3'b001;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cc <= 3'b010;
		else if (mem_stage.cw.valid && mem_stage.cw.load_cc)
			cc <= cc_next;
	end

	// resolved here, flushes everything younger
	assign branch_enable = mem_stage.cw.valid && (mem_stage.cw.opcode == op_br) &&
		|(mem_stage.cw.br_nzp & cc);
	assign br_target = mem_alu;

endmodule : writeback_module

// ==== rtl/memory_module.sv ====
`timescale 1ns/100ps

module memory_module import lc3b_types::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  lc3b_stage   ex_stage,
	input  lc3b_word    alu,
	input  lc3b_word    store_data,
	input  logic        branch_enable,
	output lc3b_word    mem_addr2,
	output logic        mem_read2,
	output logic        mem_write2,
	output lc3b_word    mem_wdata2,
	input  lc3b_word    mem_rdata2,
	output lc3b_stage   mem_stage,
	output lc3b_word    mem_alu,
	output lc3b_word    mdr
);

	lc3b_control wb_cw;
	lc3b_word    wb_ir;
	lc3b_word    wb_pc;
	lc3b_word    alu_q;
	lc3b_word    mdr_q;

	// data port, same-cycle response
	assign mem_addr2 = alu;
	assign mem_wdata2 = store_data;
	// slot right behind a taken branch is squashed here
	assign mem_read2 = ex_stage.cw.valid && ex_stage.cw.mem_read && !branch_enable;
	assign mem_write2 = ex_stage.cw.valid && ex_stage.cw.mem_write && !branch_enable;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wb_cw <= '0;
		else
			wb_cw <= branch_enable ? '0 : ex_stage.cw;
	end

	always_ff @(posedge clk) begin
		wb_ir <= ex_stage.ir;
		wb_pc <= ex_stage.pc;
		alu_q <= alu;
		mdr_q <= mem_rdata2;
	end

	assign mem_stage = '{ir: wb_ir, pc: wb_pc, cw: wb_cw};
	assign mem_alu = alu_q;
	assign mdr = mdr_q;

endmodule : memory_module

// ==== rtl/execution_module.sv ====
`timescale 1ns/100ps

module execution_module import lc3b_types::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  lc3b_stage   id_stage,
	input  lc3b_word    sr1,
	input  lc3b_word    sr2,
	input  logic        branch_enable,
	output lc3b_stage   ex_stage,
	output lc3b_word    alu,
	output lc3b_word    store_data
);

	lc3b_word    imm5;
	lc3b_word    offset6;
	lc3b_word    offset9;
	lc3b_word    pc_target;
	lc3b_word    operand_b;
	lc3b_word    alu_result;
	lc3b_control ex_cw;
	lc3b_word    ex_ir;
	lc3b_word    ex_pc;
	lc3b_word    alu_q;
	lc3b_word    store_q;

	assign imm5 = {{11{id_stage.ir[4]}}, id_stage.ir[4:0]};
	assign offset6 = {{9{id_stage.ir[5]}}, id_stage.ir[5:0], 1'b0};  // word offset
	assign offset9 = {{6{id_stage.ir[8]}}, id_stage.ir[8:0], 1'b0};

	// LEA and BR are relative to the incremented pc
	assign pc_target = id_stage.pc + 16'd2 + offset9;

	always_comb begin
		if (!id_stage.cw.use_imm)
			operand_b = sr2;
		else if (id_stage.cw.opcode == op_ldr || id_stage.cw.opcode == op_str)
			operand_b = offset6;
		else
			operand_b = imm5;
	end

	always_comb begin
		case (id_stage.cw.aluop)
			alu_add: alu_result = sr1 + operand_b;
			alu_and: alu_result = sr1 & operand_b;
			alu_not: alu_result = ~sr1;
			default: alu_result = pc_target;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ex_cw <= '0;
		else
			ex_cw <= branch_enable ? '0 : id_stage.cw;
	end

	always_ff @(posedge clk) begin
		ex_ir <= id_stage.ir;
		ex_pc <= id_stage.pc;
		alu_q <= alu_result;
		store_q <= sr2;  // STR source register
	end

	assign ex_stage = '{ir: ex_ir, pc: ex_pc, cw: ex_cw};
	assign alu = alu_q;
	assign store_data = store_q;

endmodule : execution_module

// ==== rtl/instruction_decode.sv ====
`timescale 1ns/100ps
`include "lc3b_consts.svh"

module instruction_decode import lc3b_types::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  lc3b_stage   if_stage,
	input  logic        branch_enable,
	input  logic        wb_load,
	input  lc3b_reg     wb_dest,
	input  lc3b_word    wb_data,
	output logic        stall,
	output lc3b_stage   id_stage,
	output lc3b_word    sr1,
	output lc3b_word    sr2
);

	lc3b_word    regs [`LC3B_NUM_REGS];
	lc3b_opcode  opcode;
	lc3b_control dec_cw;
	lc3b_reg     sr1_idx;
	lc3b_reg     sr2_idx;
	logic        reads_sr1;
	logic        reads_sr2;
	logic        is_br;
	logic        raw_hazard;
	logic        cc_hazard;
	lc3b_word    sr1_val;
	lc3b_word    sr2_val;
	lc3b_word    id_ir;
	lc3b_word    id_pc;
	lc3b_control id_cw;
	lc3b_control exm_cw;   // copy of what execute holds in EX/MEM
	lc3b_word    sr1_q;
	lc3b_word    sr2_q;

	function automatic logic writes_reg(lc3b_control cw, lc3b_reg r);
		return cw.valid && cw.regfile_load && (cw.dest == r);
	endfunction

	assign opcode = lc3b_opcode'(if_stage.ir[15:12]);

	// control ROM
	always_comb begin
		dec_cw = '0;
		dec_cw.valid = if_stage.cw.valid;
		dec_cw.opcode = opcode;
		case (opcode)
			op_add, op_and: begin
				dec_cw.aluop = (opcode == op_add) ? alu_add : alu_and;
				dec_cw.use_imm = if_stage.ir[5];
				dec_cw.dest = if_stage.ir[11:9];
				dec_cw.regfile_load = 1'b1;
				dec_cw.load_cc = 1'b1;
			end
			op_not: begin
				dec_cw.aluop = alu_not;
				dec_cw.dest = if_stage.ir[11:9];
				dec_cw.regfile_load = 1'b1;
				dec_cw.load_cc = 1'b1;
			end
			op_ldr: begin
				dec_cw.aluop = alu_add;  // base + offset6
				dec_cw.use_imm = 1'b1;
				dec_cw.dest = if_stage.ir[11:9];
				dec_cw.regfile_load = 1'b1;
				dec_cw.load_cc = 1'b1;
				dec_cw.mem_read = 1'b1;
			end
			op_str: begin
				dec_cw.aluop = alu_add;
				dec_cw.use_imm = 1'b1;
				dec_cw.mem_write = 1'b1;
			end
			op_lea: begin
				dec_cw.aluop = alu_pass;
				dec_cw.dest = if_stage.ir[11:9];
				dec_cw.regfile_load = 1'b1;
			end
			op_br: begin
				dec_cw.aluop = alu_pass;  // target from pc adder
				dec_cw.br_nzp = if_stage.ir[11:9];
			end
			default: dec_cw.aluop = alu_pass;  // unsupported, no side effects
		endcase
	end

	// source operands
	assign sr1_idx = if_stage.ir[8:6];
	assign sr2_idx = (opcode == op_str) ? if_stage.ir[11:9] : if_stage.ir[2:0];
	assign reads_sr1 = (opcode == op_add) || (opcode == op_and) || (opcode == op_not) ||
		(opcode == op_ldr) || (opcode == op_str);
	assign reads_sr2 = (((opcode == op_add) || (opcode == op_and)) && !if_stage.ir[5]) ||
		(opcode == op_str);
	assign is_br = (opcode == op_br);

	// writeback result bypassed into the read
	assign sr1_val = (wb_load && wb_dest == sr1_idx) ? wb_data : regs[sr1_idx];
	assign sr2_val = (wb_load && wb_dest == sr2_idx) ? wb_data : regs[sr2_idx];

	// interlock against producers in EX and MEM
	assign raw_hazard = (reads_sr1 && (writes_reg(id_cw, sr1_idx) || writes_reg(exm_cw, sr1_idx))) ||
		(reads_sr2 && (writes_reg(id_cw, sr2_idx) || writes_reg(exm_cw, sr2_idx)));
	assign cc_hazard = is_br && ((id_cw.valid && id_cw.load_cc) || (exm_cw.valid && exm_cw.load_cc));
	assign stall = if_stage.cw.valid && !branch_enable && (raw_hazard || cc_hazard);

	always_ff @(posedge clk) begin
		if (wb_load)
			regs[wb_dest] <= wb_data;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_cw <= '0;
			exm_cw <= '0;
		end else if (branch_enable) begin
			id_cw <= '0;
			exm_cw <= '0;
		end else begin
			id_cw <= stall ? '0 : dec_cw;  // bubble on stall
			exm_cw <= id_cw;
		end
	end

	always_ff @(posedge clk) begin
		id_ir <= (stall || branch_enable) ? `LC3B_NOP_WORD : if_stage.ir;
		id_pc <= if_stage.pc;
		sr1_q <= sr1_val;
		sr2_q <= sr2_val;
	end

	assign id_stage = '{ir: id_ir, pc: id_pc, cw: id_cw};
	assign sr1 = sr1_q;
	assign sr2 = sr2_q;

endmodule : instruction_decode

// ==== rtl/instruction_fetch.sv ====
`timescale 1ns/100ps
`include "lc3b_consts.svh"

module instruction_fetch import lc3b_types::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        stall,
	input  logic        branch_enable,
	input  lc3b_word    br_target,
	output lc3b_word    mem_addr1,
	output logic        mem_read1,
	input  lc3b_word    mem_rdata1,
	output lc3b_stage   if_stage
);

	lc3b_word    pc;
	lc3b_word    pc_next;
	logic        run;       // set one cycle after reset release
	lc3b_control fetch_cw;
	lc3b_word    if_ir;
	lc3b_word    if_pc;
	lc3b_control if_cw;

	always_comb begin
		pc_next = pc;
		if (branch_enable)
			pc_next = br_target;  // redirect wins over stall
		else if (run && !stall)
			pc_next = pc + 16'd2;
	end

	always_comb begin
		fetch_cw = '0;
		fetch_cw.valid = run;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run <= 1'b0;
			pc <= `LC3B_RESET_PC;
			if_ir <= `LC3B_NOP_WORD;
			if_cw <= '0;
		end else begin
			run <= 1'b1;
			pc <= pc_next;
			if (branch_enable) begin
				if_ir <= `LC3B_NOP_WORD;  // flush
				if_cw <= '0;
			end else if (!stall) begin
				if_ir <= mem_rdata1;
				if_cw <= fetch_cw;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stall)
			if_pc <= pc;  // pc of the fetched word, not pc+2
	end

	assign mem_addr1 = pc;
	assign mem_read1 = run;
	assign if_stage = '{ir: if_ir, pc: if_pc, cw: if_cw};

endmodule : instruction_fetch

// ==== rtl/lc3b_types.sv ====
package lc3b_types;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;

	// LC-3b encodings of the opcodes handled here
	typedef enum logic [3:0] {
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_not = 4'b1001,
		op_lea = 4'b1110
	} lc3b_opcode;

	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass  // forwards the pc-relative adder
	} lc3b_aluop;

	typedef struct packed {
		logic       valid;
		lc3b_opcode opcode;
		lc3b_aluop  aluop;
		logic       use_imm;  // imm5 or offset6 in place of sr2
		lc3b_reg    dest;
		logic       regfile_load;
		logic       load_cc;
		logic       mem_read;
		logic       mem_write;
		logic [2:0] br_nzp;
	} lc3b_control;

	// common part of every pipeline register
	typedef struct packed {
		lc3b_word    ir;
		lc3b_word    pc;
		lc3b_control cw;
	} lc3b_stage;

endpackage : lc3b_types

// ==== rtl/lc3b_consts.svh ====
`ifndef LC3B_CONSTS_SVH
`define LC3B_CONSTS_SVH

// first fetch address out of reset
`define LC3B_RESET_PC 16'h0000

// BR with nzp = 000, never taken
`define LC3B_NOP_WORD 16'h0000

// general purpose registers R0..R7
`define LC3B_NUM_REGS 8

`endif
